//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = dcache_tb
FLIST     = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int                          LINE_WORDS = 4,
    parameter int                          MEM_WORDS  = 1024,
    parameter logic [dcache_pkg::DATA_W-1:0] FILL_XOR = 32'h5a5a_0000,
    parameter logic [31:0]                 SEED       = 32'h6985_d553
) (
    input  logic                          clk,
    input  logic                          mem_valid,
    input  logic                          mem_write,
    input  logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    input  logic [dcache_pkg::DATA_W-1:0] mem_wdata,
    output logic                          mem_ready,
    output logic [dcache_pkg::DATA_W-1:0] mem_rdata,
    output logic                          mem_last
);
    import dcache_pkg::*;

    localparam int BEAT_W    = $clog2(LINE_WORDS);
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [31:0]       lfsr;
    logic [BEAT_W-1:0] beat;
    logic [ADDR_W-1:0] beat_addr;

    // burst logs that the testbench reads back
    logic [5:0]        rd_bursts;
    logic [5:0]        wr_bursts;
    logic [ADDR_W-1:0] rd_log_addr [64];
    logic [ADDR_W-1:0] wr_log_addr [64];
    logic [DATA_W-1:0] wr_log_data [64][LINE_WORDS];

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        lfsr      = SEED;
        mem_ready = 1'b0;
        beat      = '0;
        rd_bursts = '0;
        wr_bursts = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ADDR_W'(i * STRB_W) ^ FILL_XOR;
        end
    end

    assign beat_addr = mem_addr + (ADDR_W'(beat) << ALIGN_W);
    assign mem_rdata = mem[beat_addr[ALIGN_W +: MEM_IDX_W]];
    assign mem_last  = beat == BEAT_W'(LINE_WORDS - 1);

    always @(posedge clk) begin
        // one lfsr step per ready bit
        lfsr      <= lfsr_step(lfsr);
        mem_ready <= lfsr[0];
        if (mem_valid && mem_ready) begin
            beat <= beat + 1'b1;
            if (mem_write) begin
                mem[beat_addr[ALIGN_W +: MEM_IDX_W]] <= mem_wdata;
                wr_log_data[wr_bursts][beat] <= mem_wdata;
            end
            if (mem_last) begin
                beat <= '0;
                if (mem_write) begin
                    wr_log_addr[wr_bursts] <= mem_addr;
                    wr_bursts <= wr_bursts + 1'b1;
                end else begin
                    rd_log_addr[rd_bursts] <= mem_addr;
                    rd_bursts <= rd_bursts + 1'b1;
                end
            end
        end
    end

endmodule

//--- dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int          SETS         = 16;
    localparam int          LINE_WORDS   = 4;
    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] LFSR_SEED    = 32'h6985_d553;
    localparam logic [31:0] FILL_XOR     = 32'h5a5a_0000;
    localparam int          MEM_WORDS    = 1024;
    localparam int          MEM_IDX_W    = $clog2(MEM_WORDS);
    localparam int          TABLE_LEN    = 17;
    localparam int          LINE_BYTES   = LINE_WORDS * STRB_W;
    // ram enable cycle, then the cycle with read data
    localparam int          HIT_CYCLES   = 2;

    logic              clk;
    logic              resetn;
    logic              req_valid;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_strobe;
    logic              addr_ok;
    logic              data_ok;
    logic [DATA_W-1:0] rdata;
    logic              mem_valid;
    logic              mem_write;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_ready;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_last;

    logic [ADDR_W-1:0] tbl_addr    [TABLE_LEN];
    logic [DATA_W-1:0] tbl_wdata   [TABLE_LEN];
    logic [STRB_W-1:0] tbl_strobe  [TABLE_LEN];
    logic [DATA_W-1:0] tbl_rdata   [TABLE_LEN];
    logic              tbl_fetch   [TABLE_LEN];
    logic              tbl_wb      [TABLE_LEN];
    logic [ADDR_W-1:0] tbl_wb_line [TABLE_LEN];
    logic [DATA_W-1:0] shadow      [MEM_WORDS];
    int                rows;

    dcache_top #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_dcache_top (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_strobe (req_strobe),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_last   (mem_last)
    );

    dcache_mem_model #(
        .LINE_WORDS (LINE_WORDS),
        .MEM_WORDS  (MEM_WORDS),
        .FILL_XOR   (FILL_XOR),
        .SEED       (LFSR_SEED)
    ) u_mem (
        .clk       (clk),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_last  (mem_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    function automatic logic [MEM_IDX_W-1:0] word_index(input logic [ADDR_W-1:0] addr);
        return addr[ALIGN_W +: MEM_IDX_W];
    endfunction

    function automatic logic [DATA_W-1:0] apply_strobe(input logic [DATA_W-1:0] old_word,
                                                       input logic [DATA_W-1:0] new_word,
                                                       input logic [STRB_W-1:0] strobe);
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strobe[i]) begin
                word[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return word;
    endfunction

    task automatic fill_shadow();
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = ADDR_W'(i * STRB_W) ^ FILL_XOR;
        end
    endtask

    task automatic add_row(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input logic [STRB_W-1:0] strobe, input logic fetch,
                           input logic wb, input logic [ADDR_W-1:0] wb_line);
        tbl_addr[rows]    = addr;
        tbl_wdata[rows]   = wdata;
        tbl_strobe[rows]  = strobe;
        tbl_fetch[rows]   = fetch;
        tbl_wb[rows]      = wb;
        tbl_wb_line[rows] = wb_line;
        shadow[word_index(addr)] = apply_strobe(shadow[word_index(addr)], wdata, strobe);
        tbl_rdata[rows] = shadow[word_index(addr)];
        rows++;
    endtask

    task automatic build_table();
        rows = 0;
        fill_shadow();
        // read miss in set 4 then hits and a byte write
        add_row(32'h0000_0040, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
        add_row(32'h0000_0044, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_0048, 32'hdead_beef, 4'b0101, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_0048, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
        // lines A B A in set 8 and then C evicts B
        add_row(32'h0000_0080, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
        add_row(32'h0000_0184, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
        add_row(32'h0000_0088, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_0280, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
        add_row(32'h0000_008c, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_0180, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
        // dirty victims of set 4 go back to memory
        add_row(32'h0000_004c, 32'h1234_5678, 4'b1111, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_0144, 32'hcafe_f00d, 4'b1000, 1'b1, 1'b0, 32'h0);
        add_row(32'h0000_0240, 32'h0, 4'b0000, 1'b1, 1'b1, 32'h0000_0040);
        add_row(32'h0000_0048, 32'h0, 4'b0000, 1'b1, 1'b1, 32'h0000_0140);
        add_row(32'h0000_014c, 32'h0, 4'b0000, 1'b1, 1'b0, 32'h0);
        add_row(32'h0000_0144, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_004c, 32'h0, 4'b0000, 1'b0, 1'b0, 32'h0);
        fill_shadow();
    endtask

    task automatic run_row(input int n);
        logic [5:0]        rd_before;
        logic [5:0]        wr_before;
        logic [ADDR_W-1:0] line;
        int                waited;
        rd_before = u_mem.rd_bursts;
        wr_before = u_mem.wr_bursts;
        line = tbl_addr[n] & ~ADDR_W'(LINE_BYTES - 1);
        @(posedge clk);
        req_valid  <= 1'b1;
        req_addr   <= tbl_addr[n];
        req_wdata  <= tbl_wdata[n];
        req_strobe <= tbl_strobe[n];
        @(negedge clk);
        // previous data_ok lasts one cycle only
        check_bit("data_ok", data_ok, 1'b0);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!data_ok);
        check_bit("addr_ok", addr_ok, 1'b1);
        check_word("rdata", rdata, tbl_rdata[n]);
        check_bit("read burst", u_mem.rd_bursts != rd_before, tbl_fetch[n]);
        check_bit("write burst", u_mem.wr_bursts != wr_before, tbl_wb[n]);
        if (tbl_fetch[n]) begin
            check_addr("fetch mem_addr", u_mem.rd_log_addr[rd_before], line);
        end else begin
            check_bit("data_ok on time", waited == HIT_CYCLES, 1'b1);
        end
        if (tbl_wb[n]) begin
            check_addr("writeback mem_addr", u_mem.wr_log_addr[wr_before], tbl_wb_line[n]);
            for (int w = 0; w < LINE_WORDS; w++) begin
                check_word("writeback mem_wdata", u_mem.wr_log_data[wr_before][w],
                           shadow[word_index(tbl_wb_line[n] + ADDR_W'(w * STRB_W))]);
            end
        end
        shadow[word_index(tbl_addr[n])] = tbl_rdata[n];
    endtask

    initial begin
        resetn     = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_strobe = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        // idle cache before the first request
        check_bit("addr_ok", addr_ok, 1'b1);
        check_bit("data_ok", data_ok, 1'b0);
        check_bit("mem_valid", mem_valid, 1'b0);
        check_bit("mem_write", mem_write, 1'b0);
        for (int n = 0; n < TABLE_LEN; n++) begin
            run_row(n);
        end
        $display("Verification passed");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + TABLE_LEN * 200) @(posedge clk);
        $display("timeout: the cache stopped answering requests");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- rtl/dcache_data_ram.sv
`timescale 1ns/1ps

module dcache_data_ram #(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                                                             clk,
    input  logic                                                             a_en,
    input  logic [dcache_pkg::index_bits(SETS)+dcache_pkg::offset_bits(LINE_WORDS):0] a_addr,
    input  logic [dcache_pkg::STRB_W-1:0]                                    a_strobe,
    input  logic [dcache_pkg::DATA_W-1:0]                                    a_wdata,
    output logic [dcache_pkg::DATA_W-1:0]                                    a_rdata,
    input  logic                                                             b_en,
    input  logic [dcache_pkg::index_bits(SETS)+dcache_pkg::offset_bits(LINE_WORDS):0] b_addr,
    input  logic [dcache_pkg::STRB_W-1:0]                                    b_strobe,
    input  logic [dcache_pkg::DATA_W-1:0]                                    b_wdata,
    output logic [dcache_pkg::DATA_W-1:0]                                    b_rdata
);
    import dcache_pkg::*;

    localparam int DEPTH = WAYS * SETS * LINE_WORDS;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] a_next;
    logic [DATA_W-1:0] b_next;

    function automatic logic [DATA_W-1:0] byte_merge(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    // write-first on each port
    assign a_next = byte_merge(mem[a_addr], a_wdata, a_strobe);
    assign b_next = byte_merge(mem[b_addr], b_wdata, b_strobe);

    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= a_next;
            if (|a_strobe) begin
                mem[a_addr] <= a_next;
            end
        end
        if (b_en) begin
            b_rdata <= b_next;
            if (|b_strobe) begin
                mem[b_addr] <= b_next;
            end
        end
    end

endmodule

//--- rtl/dcache_pkg.sv
package dcache_pkg;

    // bus geometry
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int ALIGN_W = $clog2(STRB_W);

    // replacement state is a single bit per set, so two ways only
    localparam int WAYS = 2;

    // word select inside a line
    function automatic int offset_bits(input int line_words);
        return $clog2(line_words);
    endfunction

    // set select
    function automatic int index_bits(input int sets);
        return $clog2(sets);
    endfunction

    // whatever is left above index and offset
    function automatic int tag_bits(input int sets, input int line_words);
        int low_bits;
        low_bits = index_bits(sets) + offset_bits(line_words) + ALIGN_W;
        return ADDR_W - low_bits;
    endfunction

endpackage

//--- rtl/dcache_refill.sv
`timescale 1ns/1ps

module dcache_refill #(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                                                             clk,
    input  logic                                                             resetn,
    input  logic                                                             start,
    input  logic [dcache_pkg::ADDR_W-1:0]                                    miss_addr,
    input  logic                                                             victim_way,
    input  logic                                                             victim_dirty,
    input  logic [dcache_pkg::tag_bits(SETS, LINE_WORDS)-1:0]                victim_tag,
    output logic                                                             done,
    output logic                                                             fill_en,
    output logic                                                             fill_way,
    output logic [dcache_pkg::tag_bits(SETS, LINE_WORDS)-1:0]                fill_tag,
    output logic                                                             fill_dirty,
    output logic                                                             b_en,
    output logic [dcache_pkg::index_bits(SETS)+dcache_pkg::offset_bits(LINE_WORDS):0] b_addr,
    output logic [dcache_pkg::STRB_W-1:0]                                    b_strobe,
    output logic [dcache_pkg::DATA_W-1:0]                                    b_wdata,
    input  logic [dcache_pkg::DATA_W-1:0]                                    b_rdata,
    output logic                                                             mem_valid,
    output logic                                                             mem_write,
    output logic [dcache_pkg::ADDR_W-1:0]                                    mem_addr,
    output logic [dcache_pkg::DATA_W-1:0]                                    mem_wdata,
    input  logic                                                             mem_ready,
    input  logic [dcache_pkg::DATA_W-1:0]                                    mem_rdata,
    input  logic                                                             mem_last
);
    import dcache_pkg::*;

    localparam int OFF_W = offset_bits(LINE_WORDS);
    localparam int IDX_W = index_bits(SETS);
    localparam int TAG_W = tag_bits(SETS, LINE_WORDS);

    localparam logic [1:0] S_IDLE      = 2'd0;
    localparam logic [1:0] S_WRITEBACK = 2'd1;
    localparam logic [1:0] S_FETCH     = 2'd2;

    logic [1:0]       state;
    logic             way_q;
    logic [IDX_W-1:0] idx_q;
    logic [TAG_W-1:0] tag_q;
    logic [TAG_W-1:0] vtag_q;
    logic [OFF_W-1:0] beat;
    logic [OFF_W-1:0] rd_off;
    logic [OFF_W-1:0] rd_off_q;
    logic             rd_busy;
    logic             rd_vld;
    logic             wb_go;
    logic             beat_done;
    logic [DATA_W-1:0] line_buf [LINE_WORDS];

    assign beat_done = mem_valid && mem_ready;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= S_IDLE;
            beat    <= '0;
            rd_off  <= '0;
            rd_busy <= 1'b0;
            rd_vld  <= 1'b0;
            wb_go   <= 1'b0;
            done    <= 1'b0;
        end else begin
            done   <= 1'b0;
            rd_vld <= rd_busy;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= victim_dirty ? S_WRITEBACK : S_FETCH;
                        rd_busy <= victim_dirty;
                        rd_off  <= '0;
                        beat    <= '0;
                        wb_go   <= 1'b0;
                    end
                end
                S_WRITEBACK: begin
                    // burst waits one cycle for the first ram word
                    wb_go <= 1'b1;
                    if (rd_busy) begin
                        rd_off <= rd_off + 1'b1;
                        if (rd_off == OFF_W'(LINE_WORDS - 1)) begin
                            rd_busy <= 1'b0;
                        end
                    end
                    if (beat_done) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= S_FETCH;
                            beat  <= '0;
                            wb_go <= 1'b0;
                        end
                    end
                end
                S_FETCH: begin
                    if (beat_done) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_off_q <= rd_off;
        if (rd_vld) begin
            line_buf[rd_off_q] <= b_rdata;
        end
        if (state == S_IDLE && start) begin
            way_q  <= victim_way;
            vtag_q <= victim_tag;
            tag_q  <= miss_addr[ADDR_W-1 -: TAG_W];
            idx_q  <= miss_addr[ALIGN_W+OFF_W +: IDX_W];
        end
    end

    assign mem_valid = (state == S_WRITEBACK && wb_go) || state == S_FETCH;
    assign mem_write = state == S_WRITEBACK && wb_go;
    assign mem_addr  = {(state == S_WRITEBACK) ? vtag_q : tag_q, idx_q,
                        {(OFF_W + ALIGN_W){1'b0}}};
    // word still on the ram output has not reached the buffer yet
    assign mem_wdata = (rd_vld && rd_off_q == beat) ? b_rdata : line_buf[beat];

    assign b_en     = (state == S_WRITEBACK && rd_busy) || (state == S_FETCH && mem_ready);
    assign b_addr   = {way_q, idx_q, (state == S_FETCH) ? beat : rd_off};
    assign b_strobe = {STRB_W{state == S_FETCH}};
    assign b_wdata  = mem_rdata;

    assign fill_en    = state == S_FETCH && mem_ready && mem_last;
    assign fill_way   = way_q;
    assign fill_tag   = tag_q;
    assign fill_dirty = 1'b0;

endmodule

//--- rtl/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store #(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                                            clk,
    input  logic                                            resetn,
    input  logic [dcache_pkg::ADDR_W-1:0]                   lookup_addr,
    input  logic                                            touch_en,
    input  logic                                            touch_way,
    input  logic                                            touch_write,
    input  logic                                            fill_en,
    input  logic                                            fill_way,
    input  logic [dcache_pkg::tag_bits(SETS, LINE_WORDS)-1:0] fill_tag,
    input  logic                                            fill_dirty,
    output logic                                            hit,
    output logic                                            hit_way,
    output logic                                            victim_way,
    output logic                                            victim_dirty,
    output logic [dcache_pkg::tag_bits(SETS, LINE_WORDS)-1:0] victim_tag
);
    import dcache_pkg::*;

    localparam int OFF_W = offset_bits(LINE_WORDS);
    localparam int IDX_W = index_bits(SETS);
    localparam int TAG_W = tag_bits(SETS, LINE_WORDS);

    logic [WAYS-1:0][SETS-1:0] valid_q;
    logic [WAYS-1:0][SETS-1:0] dirty_q;
    logic [SETS-1:0]           plru_q;
    logic [TAG_W-1:0]          tag_q [WAYS][SETS];

    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] idx_q;
    logic [TAG_W-1:0] tag;
    logic [WAYS-1:0]  hit_vec;

    assign idx = lookup_addr[ALIGN_W+OFF_W +: IDX_W];
    assign tag = lookup_addr[ADDR_W-1 -: TAG_W];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
        end
    end

    assign hit     = |hit_vec;
    assign hit_way = hit_vec[1];

    // empty way first, otherwise the way plru points at
    always_comb begin
        if (!valid_q[0][idx]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = plru_q[idx];
        end
    end

    assign victim_dirty = valid_q[victim_way][idx] && dirty_q[victim_way][idx];
    assign victim_tag   = tag_q[victim_way][idx];

    // touch and fill always refer to the set looked up one cycle earlier
    always_ff @(posedge clk) begin
        idx_q <= idx;
        if (fill_en) begin
            tag_q[fill_way][idx_q] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            plru_q  <= '0;
        end else begin
            if (touch_en) begin
                // next victim is the way not just used
                plru_q[idx_q] <= ~touch_way;
                if (touch_write) begin
                    dirty_q[touch_way][idx_q] <= 1'b1;
                end
            end
            if (fill_en) begin
                valid_q[fill_way][idx_q] <= 1'b1;
                dirty_q[fill_way][idx_q] <= fill_dirty;
            end
        end
    end

endmodule

//--- rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          req_valid,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr,
    input  logic [dcache_pkg::DATA_W-1:0] req_wdata,
    input  logic [dcache_pkg::STRB_W-1:0] req_strobe,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [dcache_pkg::DATA_W-1:0] rdata,
    output logic                          mem_valid,
    output logic                          mem_write,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata,
    input  logic                          mem_ready,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata,
    input  logic                          mem_last
);
    import dcache_pkg::*;

    localparam int OFF_W = offset_bits(LINE_WORDS);
    localparam int IDX_W = index_bits(SETS);
    localparam int TAG_W = tag_bits(SETS, LINE_WORDS);

    logic              accept;
    logic              stage_vld;
    logic              busy_q;
    logic              hit_q;
    logic              way_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] strobe_q;
    logic              hit_stage;
    logic              miss_stage;
    logic              way_sel;
    logic              a_en;
    logic [ADDR_W-1:0] lookup_addr;

    logic             hit;
    logic             hit_way;
    logic             victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic             fill_en;
    logic             fill_way;
    logic [TAG_W-1:0] fill_tag;
    logic             fill_dirty;
    logic             done;

    logic                   b_en;
    logic [IDX_W+OFF_W:0]   b_addr;
    logic [STRB_W-1:0]      b_strobe;
    logic [DATA_W-1:0]      b_wdata;
    logic [DATA_W-1:0]      b_rdata;

    assign accept     = req_valid && addr_ok;
    assign hit_stage  = stage_vld && hit_q;
    assign miss_stage = stage_vld && !hit_q;
    assign addr_ok    = !miss_stage && !busy_q;

    // while a miss is held the lookup follows the held request
    assign lookup_addr = addr_ok ? req_addr : addr_q;

    // replay finds its line in the way just filled
    assign way_sel = busy_q ? hit_way : way_q;
    assign a_en    = hit_stage || done;

    always_ff @(posedge clk) begin
        if (resetn) begin
            stage_vld <= 1'b0;
            busy_q    <= 1'b0;
            data_ok   <= 1'b0;
        end else begin
            stage_vld <= accept;
            data_ok   <= a_en;
            if (miss_stage) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= req_addr;
            wdata_q  <= req_wdata;
            strobe_q <= req_strobe;
            hit_q    <= hit;
            way_q    <= hit_way;
        end
    end

    dcache_tag_store #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_tag_store (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_addr  (lookup_addr),
        .touch_en     (a_en),
        .touch_way    (way_sel),
        .touch_write  (|strobe_q),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .fill_dirty   (fill_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_ram #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_data_ram (
        .clk      (clk),
        .a_en     (a_en),
        .a_addr   ({way_sel, addr_q[ALIGN_W +: IDX_W+OFF_W]}),
        .a_strobe (strobe_q),
        .a_wdata  (wdata_q),
        .a_rdata  (rdata),
        .b_en     (b_en),
        .b_addr   (b_addr),
        .b_strobe (b_strobe),
        .b_wdata  (b_wdata),
        .b_rdata  (b_rdata)
    );

    dcache_refill #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_refill (
        .clk          (clk),
        .resetn       (resetn),
        .start        (miss_stage),
        .miss_addr    (addr_q),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .done         (done),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .fill_dirty   (fill_dirty),
        .b_en         (b_en),
        .b_addr       (b_addr),
        .b_strobe     (b_strobe),
        .b_wdata      (b_wdata),
        .b_rdata      (b_rdata),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .mem_last     (mem_last)
    );

endmodule

//--- vlog.f
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_ram.sv
rtl/dcache_refill.sv
rtl/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv
